// File: Bender.yml
package:
  name: sr_adapt

sources:
  # Design sources in compile order
  - design/sr_pkg.sv
  - design/sr_clk_ctl.sv
  - design/sr_tx_serializer.sv
  - design/sr_rx_deserializer.sv
  - design/sr_adapt_top.sv

  # Verification sources
  - target: test
    files:
      - verif/tb_sr_adapt.sv

// File: design/sr_adapt_top.sv
/* Sideband SR channel top: clock control, serializer and deserializer */

`timescale 1ns/100ps

module sr_adapt_top import sr_pkg::*; (
  input  logic        i_tx_sr_clk,
  input  logic        i_reset,
  // Configuration
  input  sr_clk_cfg_t i_cfg,
  // Transmit side
  input  sr_word_t    i_tx_word,
  output logic        o_tx_ack,
  output sr_link_t    o_link,
  // Receive side
  input  sr_link_t    i_link,
  output sr_word_t    o_rx_word,
  output logic        o_rx_valid,
  output logic        o_frame_err
);

  logic shift_stb;  // One-cycle shift strobe at the selected rate

  ////////////////////
  // Clock control
  ////////////////////

  sr_clk_ctl u_clk_ctl (
    .i_tx_sr_clk (i_tx_sr_clk),
    .i_reset     (i_reset),
    .i_cfg       (i_cfg),
    .o_shift_stb (shift_stb)
  );

  ////////////////////
  // Transmit path
  ////////////////////

  sr_tx_serializer u_tx (
    .i_tx_sr_clk (i_tx_sr_clk),
    .i_reset     (i_reset),
    .i_shift_stb (shift_stb),
    .i_tx_word   (i_tx_word),
    .o_tx_ack    (o_tx_ack),
    .o_link      (o_link)
  );

  ////////////////////
  // Receive path
  ////////////////////

  // Far side link is looped back outside in single-die tests
  sr_rx_deserializer u_rx (
    .i_tx_sr_clk (i_tx_sr_clk),
    .i_reset     (i_reset),
    .i_link      (i_link),
    .o_rx_word   (o_rx_word),
    .o_rx_valid  (o_rx_valid),
    .o_frame_err (o_frame_err)
  );

endmodule

// File: design/sr_clk_ctl.sv
/* Shift-rate divider with scan override and shift gating */

`timescale 1ns/100ps

module sr_clk_ctl import sr_pkg::*; (
  input  logic        i_tx_sr_clk,
  input  logic        i_reset,
  input  sr_clk_cfg_t i_cfg,
  output logic        o_shift_stb
);

  logic [1:0] live_last;  // Rate minus one from the current config
  logic [1:0] held_last;  // Rate minus one of the period in progress
  logic [1:0] eff_last;
  logic [1:0] div_cnt;
  logic       run;

  ////////////////////
  // Rate selection
  ////////////////////

  always_comb begin
    if (!i_cfg.scan_mode_n) begin
      live_last = 2'd0;  // Scan forces the undivided rate
    end else begin
      case (i_cfg.div_sel)
        DIV_SEL_1: live_last = 2'd0;
        DIV_SEL_2: live_last = 2'd1;
        DIV_SEL_4: live_last = 2'd3;
        default:   live_last = 2'd3;  // Code 3 also divides by 4
      endcase
    end
  end

  // A new rate is picked up only when a period starts at count zero
  assign eff_last = (div_cnt == 2'd0) ? live_last : held_last;

  // Gating only applies outside scan mode
  assign run = !i_cfg.scg_en || !i_cfg.scan_mode_n;

  ////////////////////
  // Divide counter
  ////////////////////

  always_ff @(posedge i_tx_sr_clk) begin
    if (i_reset) begin
      div_cnt     <= 2'd0;
      held_last   <= 2'd0;
      o_shift_stb <= 1'b0;
    end else if (run) begin
      held_last <= eff_last;
      if (div_cnt == eff_last) begin
        div_cnt     <= 2'd0;  // Wrap and fire one strobe
        o_shift_stb <= 1'b1;
      end else begin
        div_cnt     <= div_cnt + 2'd1;
        o_shift_stb <= 1'b0;
      end
    end else begin
      o_shift_stb <= 1'b0;  // Counter holds while gated
    end
  end

endmodule

// File: design/sr_pkg.sv
/* Shared widths, word and counter types, divide-select codes
   and packed structs for the sideband shift-register channel */

package sr_pkg;

  ////////////////////
  // Link widths
  ////////////////////

  localparam int SR_WIDTH = 16;  // Bits per status word
  localparam int SR_CNT_W = 4;   // Bit position counter width

  typedef logic [SR_WIDTH-1:0] sr_word_t;  // One status word
  typedef logic [SR_CNT_W-1:0] sr_cnt_t;   // Bit position within a frame
  typedef logic [1:0]          sr_div_sel_t;  // Shift-rate select

  ////////////////////
  // Rate select codes
  ////////////////////

  // Code 3 is not named and also selects divide by 4
  localparam sr_div_sel_t DIV_SEL_1 = 2'd0;  // Undivided
  localparam sr_div_sel_t DIV_SEL_2 = 2'd1;  // Divide by 2
  localparam sr_div_sel_t DIV_SEL_4 = 2'd2;  // Divide by 4

  ////////////////////
  // Bundles
  ////////////////////

  typedef struct packed {
    logic        scan_mode_n;  // Scan mode, active low
    logic        scg_en;       // Shift clock gating enable
    sr_div_sel_t div_sel;      // Shift-rate select
  } sr_clk_cfg_t;

  // Forwarded strobe, serial data and last-bit marker
  typedef struct packed {
    logic strobe;
    logic data;
    logic load;
  } sr_link_t;

endpackage

// File: design/sr_rx_deserializer.sv
/* Receive deserializer assembling words on the load marker
   and flagging markers at the wrong bit position */

`timescale 1ns/100ps

module sr_rx_deserializer import sr_pkg::*; (
  input  logic     i_tx_sr_clk,
  input  logic     i_reset,
  input  sr_link_t i_link,
  output sr_word_t o_rx_word,
  output logic     o_rx_valid,
  output logic     o_frame_err
);

  sr_word_t shift_q;   // Bits received so far, MSB first
  sr_word_t assembled;
  sr_cnt_t  bit_cnt;
  logic     at_last;

  assign assembled = {shift_q[SR_WIDTH-2:0], i_link.data};
  assign at_last   = (bit_cnt == sr_cnt_t'(SR_WIDTH - 1));

  ////////////////////
  // Shift register
  ////////////////////

  always_ff @(posedge i_tx_sr_clk) begin
    if (i_link.strobe) begin
      shift_q <= assembled;
    end
  end

  // Published word is overwritten in place by the next good frame
  always_ff @(posedge i_tx_sr_clk) begin
    if (i_link.strobe && i_link.load && at_last) begin
      o_rx_word <= assembled;
    end
  end

  ////////////////////
  // Framing
  ////////////////////

  always_ff @(posedge i_tx_sr_clk) begin
    if (i_reset) begin
      bit_cnt     <= '0;
      o_rx_valid  <= 1'b0;
      o_frame_err <= 1'b0;
    end else begin
      o_rx_valid  <= 1'b0;  // Both flags are single-cycle pulses
      o_frame_err <= 1'b0;
      if (i_link.strobe) begin
        if (i_link.load) begin
          bit_cnt <= '0;  // Any marker restarts the frame
          if (at_last) begin
            o_rx_valid <= 1'b1;
          end else begin
            o_frame_err <= 1'b1;  // Marker at the wrong position
          end
        end else begin
          bit_cnt <= bit_cnt + sr_cnt_t'(1);  // Wraps after bit 15
        end
      end
    end
  end

endmodule

// File: design/sr_tx_serializer.sv
/* Transmit serializer loading a status word per frame and shifting
   it out MSB first with a last-bit load marker */

`timescale 1ns/100ps

module sr_tx_serializer import sr_pkg::*; (
  input  logic     i_tx_sr_clk,
  input  logic     i_reset,
  input  logic     i_shift_stb,
  input  sr_word_t i_tx_word,
  output logic     o_tx_ack,
  output sr_link_t o_link
);

  sr_word_t shift_q;    // Bits still to be sent, left aligned
  sr_word_t next_word;  // Word whose MSB goes out on this strobe
  sr_cnt_t  bit_cnt;
  logic     frame_start;
  logic     last_bit;

  assign frame_start = (bit_cnt == '0);
  assign last_bit    = (bit_cnt == sr_cnt_t'(SR_WIDTH - 1));

  // New word is taken in the same cycle as the first strobe of a frame
  assign next_word = frame_start ? i_tx_word : shift_q;
  assign o_tx_ack  = i_shift_stb && frame_start;

  ////////////////////
  // Shift register
  ////////////////////

  always_ff @(posedge i_tx_sr_clk) begin
    if (i_shift_stb) begin
      shift_q <= next_word << 1;
    end
  end

  // Bit position wraps from 15 back to 0, so frames run back to back
  always_ff @(posedge i_tx_sr_clk) begin
    if (i_reset) begin
      bit_cnt <= '0;
    end else if (i_shift_stb) begin
      bit_cnt <= bit_cnt + sr_cnt_t'(1);
    end
  end

  ////////////////////
  // Link register
  ////////////////////

  always_ff @(posedge i_tx_sr_clk) begin
    if (i_reset) begin
      o_link <= '0;
    end else begin
      o_link.strobe <= i_shift_stb;                // Forwarded one cycle late
      o_link.load   <= i_shift_stb && last_bit;    // Marks bit 15
      if (i_shift_stb) begin
        o_link.data <= next_word[SR_WIDTH-1];
      end
    end
  end

endmodule

// File: src.f
design/sr_pkg.sv
design/sr_clk_ctl.sv
design/sr_tx_serializer.sv
design/sr_rx_deserializer.sv
design/sr_adapt_top.sv
verif/tb_sr_adapt.sv

// File: verif/tb_sr_adapt.sv
/* Loopback testbench for the SR channel with stimulus, reference rate function,
   word scoreboard, strobe spacing and gating checks, and a watchdog */

`timescale 1ns/100ps

module tb_sr_adapt import sr_pkg::*; ();

  localparam int N_LOOP = 20;  // Frames per test
  localparam int N_RATE = 4;
  localparam int N_SCAN = 4;
  localparam int N_GATE = 3;
  localparam int N_FERR = 4;
  localparam int TOTAL_FRAMES = N_LOOP + 3 * N_RATE + N_SCAN + N_GATE + N_FERR + 10;
  localparam int WATCHDOG_NS  = TOTAL_FRAMES * 16 * 4 * 10 + 5000;

  logic        clk;
  logic        reset;
  sr_clk_cfg_t cfg;
  sr_word_t    tx_word;
  logic        tx_ack;
  sr_link_t    link_out;
  sr_link_t    link_lb;     // Looped back link seen by the receiver
  sr_word_t    rx_word;
  logic        rx_valid;
  logic        frame_err;
  logic        inject_load;  // Forces an extra load marker
  logic        word_due;
  sr_word_t    tx_q[$];      // Acknowledged words not yet received
  string       test_name;
  int          checks;
  int          mismatches;
  int          other_errs;
  int          rx_cnt;
  int          ack_cnt;
  int          stb_cnt;
  int          ferr_cnt;
  int          quiet_cnt;
  int          cyc;
  int          last_stb;
  logic        spacing_on;
  logic        have_last;
  logic        quiet;

  sr_adapt_top i_dut (
    .i_tx_sr_clk (clk),
    .i_reset     (reset),
    .i_cfg       (cfg),
    .i_tx_word   (tx_word),
    .o_tx_ack    (tx_ack),
    .o_link      (link_out),
    .i_link      (link_lb),
    .o_rx_word   (rx_word),
    .o_rx_valid  (rx_valid),
    .o_frame_err (frame_err)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always_comb begin
    link_lb = link_out;
    if (inject_load) begin
      link_lb.load = 1'b1;
    end
  end

  ////////////////////
  // Reference and checks
  ////////////////////

  // Expected strobe spacing in cycles for one config
  function automatic int exp_period(input sr_clk_cfg_t c);
    if (!c.scan_mode_n) begin
      return 1;
    end
    case (c.div_sel)
      DIV_SEL_1: return 1;
      DIV_SEL_2: return 2;
      default:   return 4;  // Codes 2 and 3
    endcase
  endfunction

  function automatic sr_clk_cfg_t make_cfg(input logic scan_n, input logic scg,
                                           input sr_div_sel_t div);
    sr_clk_cfg_t c;
    c.scan_mode_n = scan_n;
    c.scg_en      = scg;
    c.div_sel     = div;
    return c;
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks = checks + 1;
    if (exp !== act) begin
      mismatches = mismatches + 1;
      $display("MISMATCH %s expected %0h actual %0h", name, exp, act);
    end
  endtask

  ////////////////////
  // Monitors
  ////////////////////

  always @(negedge clk) begin
    cyc = cyc + 1;
    if (tx_ack) begin
      tx_q.push_back(tx_word);  // Captured at the coming rising edge
      ack_cnt  = ack_cnt + 1;
      word_due = 1'b1;
    end
    if (link_out.strobe) begin
      stb_cnt = stb_cnt + 1;
      if (spacing_on && have_last) begin
        check_val($sformatf("%s spacing", test_name), exp_period(cfg), cyc - last_stb);
      end
      last_stb  = cyc;
      have_last = spacing_on;
    end
    if (quiet && (link_out.strobe || rx_valid || tx_ack)) begin
      quiet_cnt = quiet_cnt + 1;
    end
    if (frame_err) begin
      ferr_cnt = ferr_cnt + 1;
    end
  end

  // Scoreboard pops one queued word per received word
  always @(negedge clk) begin
    if (rx_valid) begin
      rx_cnt = rx_cnt + 1;
      if (tx_q.size() == 0) begin
        other_errs = other_errs + 1;
        $display("ERROR: %s received word %0h while no word was pending", test_name, rx_word);
      end else begin
        check_val(test_name, tx_q.pop_front(), rx_word);
      end
    end
  end

  always @(posedge clk) begin
    #1;
    if (word_due) begin
      tx_word  = sr_word_t'($urandom);
      word_due = 1'b0;
    end
  end

  ////////////////////
  // Test sequences
  ////////////////////

  task automatic apply_cfg(input sr_clk_cfg_t c);
    @(posedge clk);
    #1;
    cfg = c;
  endtask

  task automatic wait_frames(input int n);
    int target;
    target = rx_cnt + n;
    wait (rx_cnt >= target);
  endtask

  task automatic wait_strobes(input int n);
    int target;
    target = stb_cnt + n;
    wait (stb_cnt >= target);
  endtask

  task automatic run_rate_test(input string name, input sr_clk_cfg_t c, input int n);
    test_name  = name;
    spacing_on = 1'b0;
    apply_cfg(c);
    wait_strobes(2);  // Old period ends at the next wrap
    have_last  = 1'b0;
    spacing_on = 1'b1;
    ferr_cnt   = 0;
    wait_frames(n);
    spacing_on = 1'b0;
    check_val($sformatf("%s frame_err", name), 0, ferr_cnt);
  endtask

  task automatic gating_test();
    int seen;
    test_name = "gating";
    apply_cfg(make_cfg(1'b1, 1'b0, DIV_SEL_2));
    wait_frames(1);
    ferr_cnt = 0;
    seen = ack_cnt;
    wait (ack_cnt > seen);
    repeat (6) @(posedge clk);
    #1;
    cfg.scg_en = 1'b1;  // Mid-frame
    repeat (3) @(posedge clk);
    quiet_cnt = 0;
    quiet     = 1'b1;
    repeat (40) @(posedge clk);
    quiet = 1'b0;
    check_val("gating activity", 0, quiet_cnt);
    #1;
    cfg.scg_en = 1'b0;
    wait_frames(N_GATE);  // First one is the interrupted word
    check_val("gating frame_err", 0, ferr_cnt);
  endtask

  task automatic frame_error_test();
    int seen;
    test_name = "frame_error";
    apply_cfg(make_cfg(1'b1, 1'b0, DIV_SEL_1));
    wait_frames(1);
    ferr_cnt = 0;
    seen = ack_cnt;
    wait (ack_cnt > seen);
    repeat (6) @(posedge clk);
    #1;
    void'(tx_q.pop_back());  // Word in flight is lost
    inject_load = 1'b1;
    @(posedge clk);
    #1;
    inject_load = 1'b0;
    wait_frames(N_FERR);
    // Extra marker flags once, then the real marker lands off position
    check_val("frame_error count", 2, ferr_cnt);
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("ERROR: watchdog expired after %0d ns, the tests did not complete", WATCHDOG_NS);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    void'($urandom(32'h5b55d248));
    checks      = 0;
    mismatches  = 0;
    other_errs  = 0;
    rx_cnt      = 0;
    ack_cnt     = 0;
    stb_cnt     = 0;
    ferr_cnt    = 0;
    quiet_cnt   = 0;
    cyc         = 0;
    last_stb    = 0;
    spacing_on  = 1'b0;
    have_last   = 1'b0;
    quiet       = 1'b0;
    word_due    = 1'b0;
    inject_load = 1'b0;
    test_name   = "reset";
    cfg         = make_cfg(1'b1, 1'b0, DIV_SEL_1);
    tx_word     = sr_word_t'($urandom);
    reset       = 1'b1;
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;

    run_rate_test("loopback_div1", make_cfg(1'b1, 1'b0, DIV_SEL_1), N_LOOP);
    for (int k = 1; k < 4; k++) begin
      run_rate_test($sformatf("rate_code%0d", k), make_cfg(1'b1, 1'b0, sr_div_sel_t'(k)), N_RATE);
    end
    run_rate_test("scan_override", make_cfg(1'b0, 1'b1, DIV_SEL_4), N_SCAN);
    gating_test();
    frame_error_test();

    $display("checks: %0d  mismatches: %0d  other errors: %0d", checks, mismatches, other_errs);
    if (mismatches == 0 && other_errs == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule
